/* axi2apb_pkg.sv */
// Shared widths, response codes and channel structs for the AXI4-to-APB bridge
// Imported by wildcard in every bridge module and in the checker

package axi2apb_pkg;

  // --------------------
  // Bus widths
  localparam int ADDR_W = 32;   // AXI and APB address
  localparam int APB_DW = 32;
  localparam int AXI_DW = 64;

  // AXI response and size codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [2:0] SIZE_64     = 3'd3;   // 8 bytes, anything else is one word

  // --------------------
  // AXI data word, either whole or as two APB lanes picked by address bit 2
  typedef union packed {
    logic [AXI_DW-1:0]             word;
    logic [1:0][APB_DW-1:0]        lane;
  } axi_data_u;

  // AW and AR payload
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        size;
  } axi_addr_t;

  typedef struct packed {
    axi_data_u  data;
    logic [1:0] resp;
    logic       last;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

  // --------------------
  // Internal command and beat records
  typedef struct packed {
    logic [ADDR_W-1:0] addr;      // Word aligned, 8-byte aligned for two beats
    logic              write;
    logic              two_beat;
    axi_data_u         wdata;
  } bridge_cmd_t;

  typedef struct packed {
    logic [ADDR_W-1:0] paddr;
    logic              pwrite;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DW-1:0] rdata;
    logic              lane;      // Target lane of the AXI word
    logic              slverr;
    logic              last;      // Final transfer of the command
    logic              write;
  } beat_rsp_t;

endpackage

/* axi_req_select.sv */
// AXI request front end of the bridge
// Accepts one read or one write (AW and W together), read first, and holds
// it as a bridge command until the response handshake reports completion

`timescale 1ns/100ps

module axi_req_select
  import axi2apb_pkg::*;
(
  input  logic        ACLK,
  input  logic        ARESETn,
  input  logic        awvalid_i,
  input  axi_addr_t   aw_i,
  output logic        awready_o,
  input  logic        wvalid_i,
  input  axi_data_u   w_i,
  output logic        wready_o,
  input  logic        arvalid_i,
  input  axi_addr_t   ar_i,
  output logic        arready_o,
  input  logic        txn_done_i,
  output logic        cmd_start_o,
  output bridge_cmd_t cmd_o
);

  logic        busy;
  logic        rd_win;
  logic        wr_win;
  axi_addr_t   req_addr;
  bridge_cmd_t cmd_q;

  // --------------------
  // Arbitration, reads win over a simultaneous write
  assign rd_win    = !busy && arvalid_i;
  assign wr_win    = !busy && !arvalid_i && awvalid_i && wvalid_i;
  assign arready_o = rd_win;
  assign awready_o = wr_win;
  assign wready_o  = wr_win;       // W taken with its AW
  assign req_addr  = rd_win ? ar_i : aw_i;

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      busy        <= 1'b0;
      cmd_start_o <= 1'b0;
    end
    else
    begin
      cmd_start_o <= rd_win || wr_win;
      if (rd_win || wr_win)
        busy <= 1'b1;
      else if (txn_done_i)
        busy <= 1'b0;
    end
  end

  // Command capture, held stable while busy
  always_ff @(posedge ACLK)
  begin
    if (rd_win || wr_win)
    begin
      cmd_q.two_beat <= (req_addr.size == SIZE_64);
      if (req_addr.size == SIZE_64)
        cmd_q.addr <= {req_addr.addr[ADDR_W-1:3], 3'b000};
      else
        cmd_q.addr <= {req_addr.addr[ADDR_W-1:2], 2'b00};
      cmd_q.write <= wr_win;
      cmd_q.wdata <= w_i;
    end
  end

  assign cmd_o = cmd_q;

  // Completion only arrives for a command in flight
  a_done_when_busy: assert property (@(posedge ACLK) disable iff (!ARESETn)
    txn_done_i |-> busy);

endmodule

/* apb_access_seq.sv */
// APB master sequencer of the bridge
// Runs one transfer for a 32-bit command and two for a 64-bit command,
// then reports each finished transfer as a beat one cycle after PREADY

`timescale 1ns/100ps

module apb_access_seq
  import axi2apb_pkg::*;
(
  input  logic              ACLK,
  input  logic              ARESETn,
  input  logic              cmd_start_i,
  input  bridge_cmd_t       cmd_i,
  output logic              psel_o,
  output logic              penable_o,
  output apb_req_t          apb_o,
  input  logic [APB_DW-1:0] prdata_i,
  input  logic              pready_i,
  input  logic              pslverr_i,
  output logic              beat_valid_o,
  output beat_rsp_t         beat_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } apb_state_e;

  apb_state_e state_q;
  logic       second_q;     // Second transfer of a 64-bit command
  logic       lane;
  logic       last_beat;
  logic       xfer_done;

  // --------------------
  // Request fields, derived from the held command
  assign lane      = cmd_i.addr[2] | second_q;
  assign last_beat = !cmd_i.two_beat || second_q;
  assign xfer_done = penable_o && pready_i;

  assign psel_o       = (state_q != ST_IDLE);
  assign penable_o    = (state_q == ST_ACCESS);
  assign apb_o.paddr  = {cmd_i.addr[ADDR_W-1:3], lane, 2'b00};
  assign apb_o.pwrite = cmd_i.write;
  assign apb_o.pwdata = cmd_i.wdata.lane[lane];   // Lane follows address bit 2

  // --------------------
  // Transfer FSM
  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      state_q      <= ST_IDLE;
      second_q     <= 1'b0;
      beat_valid_o <= 1'b0;
    end
    else
    begin
      beat_valid_o <= xfer_done;
      case (state_q)
        ST_IDLE:
        begin
          if (cmd_start_i)
          begin
            state_q  <= ST_SETUP;
            second_q <= 1'b0;
          end
        end
        ST_SETUP: state_q <= ST_ACCESS;
        ST_ACCESS:
        begin
          if (pready_i && last_beat)
          begin
            state_q  <= ST_IDLE;
            second_q <= 1'b0;
          end
          else if (pready_i)
          begin
            state_q  <= ST_SETUP;   // Back-to-back second transfer
            second_q <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Beat record of the finished transfer
  always_ff @(posedge ACLK)
  begin
    if (xfer_done)
    begin
      beat_o.rdata  <= prdata_i;
      beat_o.lane   <= lane;
      beat_o.slverr <= pslverr_i;
      beat_o.last   <= last_beat;
      beat_o.write  <= cmd_i.write;
    end
  end

  // New command only reaches an idle sequencer
  a_start_idle: assert property (@(posedge ACLK) disable iff (!ARESETn)
    cmd_start_i |-> (state_q == ST_IDLE));

  // Held command keeps the request steady through wait states
  a_req_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (penable_o && !pready_i) |=> $stable(apb_o));

endmodule

/* axi_resp_hold.sv */
// Response stage of the bridge
// Collects read lanes and error status from the APB beats, then holds R or B
// until the master accepts it and signals the end of the transaction

`timescale 1ns/100ps

module axi_resp_hold
  import axi2apb_pkg::*;
(
  input  logic      ACLK,
  input  logic      ARESETn,
  input  logic      beat_valid_i,
  input  beat_rsp_t beat_i,
  output logic      rvalid_o,
  output axi_r_t    r_o,
  input  logic      rready_i,
  output logic      bvalid_o,
  output axi_b_t    b_o,
  input  logic      bready_i,
  output logic      txn_done_o
);

  axi_data_u rdata_q;   // Lane not read by a 32-bit access stays zero
  logic      err_q;     // Sticky over both transfers
  logic      rvalid_q;
  logic      bvalid_q;
  logic [1:0] resp;

  assign txn_done_o = (rvalid_q && rready_i) || (bvalid_q && bready_i);
  assign resp       = err_q ? RESP_SLVERR : RESP_OKAY;

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      rdata_q.word <= '0;
      err_q        <= 1'b0;
      rvalid_q     <= 1'b0;
      bvalid_q     <= 1'b0;
    end
    else if (txn_done_o)
    begin
      rdata_q.word <= '0;   // Fresh for the next transaction
      err_q        <= 1'b0;
      rvalid_q     <= 1'b0;
      bvalid_q     <= 1'b0;
    end
    else if (beat_valid_i)
    begin
      if (!beat_i.write)
        rdata_q.lane[beat_i.lane] <= beat_i.rdata;
      err_q <= err_q | beat_i.slverr;
      if (beat_i.last)
      begin
        rvalid_q <= !beat_i.write;
        bvalid_q <= beat_i.write;
      end
    end
  end

  // --------------------
  // AXI outputs
  assign rvalid_o = rvalid_q;
  assign bvalid_o = bvalid_q;
  assign r_o.data = rdata_q;
  assign r_o.resp = resp;
  assign r_o.last = 1'b1;      // Single beat only
  assign b_o.resp = resp;

  // No APB beat while a response is held
  a_no_beat_held: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (rvalid_o || bvalid_o) |-> !beat_valid_i);

  // Stalled read response keeps its payload
  a_r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (rvalid_o && !rready_i) |=> rvalid_o && $stable(r_o));

endmodule

/* axi2apb_bridge.sv */
// AXI4-to-APB bridge top level
// Single-beat 32-bit and 64-bit AXI accesses become one or two APB transfers,
// one transaction at a time

`timescale 1ns/100ps

module axi2apb_bridge
  import axi2apb_pkg::*;
(
  input  logic              ACLK,
  input  logic              ARESETn,
  // AXI slave side
  input  logic              awvalid_i,
  input  axi_addr_t         aw_i,
  output logic              awready_o,
  input  logic              wvalid_i,
  input  axi_data_u         w_i,
  output logic              wready_o,
  input  logic              arvalid_i,
  input  axi_addr_t         ar_i,
  output logic              arready_o,
  output logic              rvalid_o,
  output axi_r_t            r_o,
  input  logic              rready_i,
  output logic              bvalid_o,
  output axi_b_t            b_o,
  input  logic              bready_i,
  // APB master side
  output logic              psel_o,
  output logic              penable_o,
  output apb_req_t          apb_o,
  input  logic [APB_DW-1:0] prdata_i,
  input  logic              pready_i,
  input  logic              pslverr_i
);

  logic        cmd_start;
  bridge_cmd_t cmd;
  logic        beat_valid;
  beat_rsp_t   beat;
  logic        txn_done;   // R or B accepted

  axi_req_select u_req_select (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .awvalid_i   (awvalid_i),
    .aw_i        (aw_i),
    .awready_o   (awready_o),
    .wvalid_i    (wvalid_i),
    .w_i         (w_i),
    .wready_o    (wready_o),
    .arvalid_i   (arvalid_i),
    .ar_i        (ar_i),
    .arready_o   (arready_o),
    .txn_done_i  (txn_done),
    .cmd_start_o (cmd_start),
    .cmd_o       (cmd)
  );

  apb_access_seq u_access_seq (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .cmd_start_i  (cmd_start),
    .cmd_i        (cmd),
    .psel_o       (psel_o),
    .penable_o    (penable_o),
    .apb_o        (apb_o),
    .prdata_i     (prdata_i),
    .pready_i     (pready_i),
    .pslverr_i    (pslverr_i),
    .beat_valid_o (beat_valid),
    .beat_o       (beat)
  );

  axi_resp_hold u_resp_hold (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .beat_valid_i (beat_valid),
    .beat_i       (beat),
    .rvalid_o     (rvalid_o),
    .r_o          (r_o),
    .rready_i     (rready_i),
    .bvalid_o     (bvalid_o),
    .b_o          (b_o),
    .bready_i     (bready_i),
    .txn_done_o   (txn_done)
  );

endmodule

/* axi2apb_checker.sv */
// Scoreboard for the AXI4-to-APB bridge testbench
// Watches the DUT ports mid-cycle, predicts R and B from a shadow memory and
// checks the APB sequence, response order and back-pressure behavior

`timescale 1ns/100ps

module axi2apb_checker
  import axi2apb_pkg::*;
(
  input  logic      ACLK,
  input  logic      ARESETn,
  input  logic      awvalid_i,
  input  logic      awready_i,
  input  axi_addr_t aw_i,
  input  logic      wvalid_i,
  input  logic      wready_i,
  input  axi_data_u w_i,
  input  logic      arvalid_i,
  input  logic      arready_i,
  input  axi_addr_t ar_i,
  input  logic      rvalid_i,
  input  logic      rready_i,
  input  axi_r_t    r_i,
  input  logic      bvalid_i,
  input  logic      bready_i,
  input  axi_b_t    b_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pready_i,
  input  apb_req_t  apb_i,
  output int        check_cnt_o,
  output int        err_cnt_o
);

  logic [31:0] shadow [0:1023];   // Same start pattern as the APB slave model
  axi_r_t      exp_rsp_q[$];      // Expected R or B, in acceptance order
  logic        exp_wr_q[$];
  apb_req_t    exp_apb_q[$];      // Transfers still owed by the DUT
  int          checks = 0;
  int          errors = 0;
  logic        prev_setup;
  logic        prev_wait;
  logic        prev_rstall;
  logic        prev_bstall;
  apb_req_t    prev_apb;
  axi_r_t      prev_r;
  axi_b_t      prev_b;

  assign check_cnt_o = checks;
  assign err_cnt_o   = errors;

  initial
  begin
    for (int i = 0; i < 1024; i++)
      shadow[i[9:0]] = {~i[9:0], 6'h2b, i[9:0], 6'h15};
  end

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  // --------------------
  // Reference model
  function automatic axi_r_t ref_result(input axi_addr_t a);
    axi_r_t     r;
    logic [9:0] idx;
    idx         = a.addr[11:2];
    r.data.word = '0;              // Lane not read stays zero
    if (a.size == SIZE_64)
    begin
      r.data.lane[0] = shadow[{idx[9:1], 1'b0}];
      r.data.lane[1] = shadow[{idx[9:1], 1'b1}];
    end
    else
      r.data.lane[idx[0]] = shadow[idx];
    r.resp = a.addr[11] ? RESP_SLVERR : RESP_OKAY;   // Slave flags bit 11
    r.last = 1'b1;
    return r;
  endfunction

  // Queues the APB transfers of a request, writes also land in the shadow
  task automatic expect_transfers(input axi_addr_t a, input logic wr, input axi_data_u d);
    apb_req_t t;
    t.pwrite = wr;
    if (a.size == SIZE_64)
    begin
      t.paddr  = {a.addr[31:3], 3'b000};
      t.pwdata = d.lane[0];
      exp_apb_q.push_back(t);
      t.paddr  = {a.addr[31:3], 3'b100};
      t.pwdata = d.lane[1];
      exp_apb_q.push_back(t);
      if (wr)
      begin
        shadow[{a.addr[11:3], 1'b0}] = d.lane[0];
        shadow[{a.addr[11:3], 1'b1}] = d.lane[1];
      end
    end
    else
    begin
      t.paddr  = {a.addr[31:2], 2'b00};
      t.pwdata = d.lane[a.addr[2]];
      exp_apb_q.push_back(t);
      if (wr)
        shadow[a.addr[11:2]] = d.lane[a.addr[2]];
    end
  endtask

  task automatic check_response(input logic is_wr);
    axi_r_t e;
    logic   e_wr;
    if (exp_rsp_q.size() == 0)
    begin
      note_failure("response handshake without an accepted request");
      return;
    end
    e    = exp_rsp_q.pop_front();
    e_wr = exp_wr_q.pop_front();
    if (exp_apb_q.size() != 0)
      note_failure("response before all APB transfers of the request finished");
    if (e_wr != is_wr)
      note_failure("responses returned out of request order");
    else if (is_wr)
      check_eq("b_o.resp", 64'(b_i.resp), 64'(e.resp));
    else
    begin
      check_eq("r_o.data", r_i.data.word, e.data.word);
      check_eq("r_o.resp", 64'(r_i.resp), 64'(e.resp));
      check_eq("r_o.last", 64'(r_i.last), 64'(e.last));
    end
  endtask

  // --------------------
  // Mid-cycle monitor, all signals settled
  always @(negedge ACLK)
  begin : monitor
    apb_req_t t;
    if (!ARESETn)
    begin
      prev_setup  = 1'b0;
      prev_wait   = 1'b0;
      prev_rstall = 1'b0;
      prev_bstall = 1'b0;
    end
    else
    begin
      if (penable_i && !psel_i)
        note_failure("PENABLE high without PSEL");
      if (prev_setup || prev_wait)
      begin
        if (!(psel_i && penable_i))
          note_failure("APB transfer left its access phase before PREADY");
        check_eq("apb_o.paddr", 64'(apb_i.paddr), 64'(prev_apb.paddr));
        check_eq("apb_o.pwrite", 64'(apb_i.pwrite), 64'(prev_apb.pwrite));
        check_eq("apb_o.pwdata", 64'(apb_i.pwdata), 64'(prev_apb.pwdata));
      end
      else if (psel_i && penable_i)
        note_failure("APB access phase without a setup cycle");
      if (psel_i && penable_i && pready_i)
      begin
        if (exp_apb_q.size() == 0)
          note_failure("APB transfer with no pending request");
        else
        begin
          t = exp_apb_q.pop_front();
          check_eq("apb_o.paddr", 64'(apb_i.paddr), 64'(t.paddr));
          check_eq("apb_o.pwrite", 64'(apb_i.pwrite), 64'(t.pwrite));
          if (t.pwrite)
            check_eq("apb_o.pwdata", 64'(apb_i.pwdata), 64'(t.pwdata));
        end
      end

      // Back-pressure
      if (prev_rstall)
      begin
        if (!rvalid_i)
          note_failure("RVALID dropped before RREADY");
        check_eq("r_o.data", r_i.data.word, prev_r.data.word);
        check_eq("r_o.resp", 64'(r_i.resp), 64'(prev_r.resp));
      end
      if (prev_bstall)
      begin
        if (!bvalid_i)
          note_failure("BVALID dropped before BREADY");
        check_eq("b_o.resp", 64'(b_i.resp), 64'(prev_b.resp));
      end
      if ((rvalid_i || bvalid_i) && (arready_i || awready_i || wready_i))
        note_failure("AXI request ready raised while a response is pending");
      if ((rvalid_i || bvalid_i) && psel_i)
        note_failure("APB transfer started while a response is pending");

      // Read priority over a waiting write
      if (arvalid_i && (awready_i || wready_i))
        note_failure("write accepted while a read request was waiting");

      // Accepted requests
      if (arvalid_i && arready_i)
      begin
        exp_rsp_q.push_back(ref_result(ar_i));
        exp_wr_q.push_back(1'b0);
        expect_transfers(ar_i, 1'b0, '0);
      end
      if (awvalid_i && awready_i && wvalid_i && wready_i)
      begin
        exp_rsp_q.push_back(ref_result(aw_i));
        exp_wr_q.push_back(1'b1);
        expect_transfers(aw_i, 1'b1, w_i);
      end
      if (rvalid_i && rready_i)
        check_response(1'b0);
      if (bvalid_i && bready_i)
        check_response(1'b1);

      prev_setup  = psel_i && !penable_i;
      prev_wait   = psel_i && penable_i && !pready_i;
      prev_rstall = rvalid_i && !rready_i;
      prev_bstall = bvalid_i && !bready_i;
    end
    prev_apb = apb_i;
    prev_r   = r_i;
    prev_b   = b_i;
  end

endmodule

/* tb_axi2apb.sv */
// Testbench top for the AXI4-to-APB bridge
// Drives directed and LCG-random single-beat AXI accesses, models an APB slave
// with wait states and an error region at address bit 11

`timescale 1ns/100ps

module tb_axi2apb
  import axi2apb_pkg::*;
();

  localparam logic [31:0] SEED       = 32'h8d9ccd04;
  localparam int          N_DIRECTED = 13;
  localparam int          N_RANDOM   = 200;
  localparam int          N_TXN      = N_DIRECTED + N_RANDOM;

  logic      ACLK = 1'b0;
  logic      ARESETn;
  logic      awvalid;
  axi_addr_t aw;
  logic      awready;
  logic      wvalid;
  axi_data_u w;
  logic      wready;
  logic      arvalid;
  axi_addr_t ar;
  logic      arready;
  logic      rvalid;
  axi_r_t    r;
  logic      rready;
  logic      bvalid;
  axi_b_t    b;
  logic      bready;
  logic      psel;
  logic      penable;
  apb_req_t  apb;
  logic [31:0] prdata;
  logic      pready;
  logic      pslverr;
  int        chk_cnt;
  int        err_cnt;

  logic [31:0] st_seed  = SEED;
  logic [31:0] slv_seed = SEED ^ 32'h0000_ffff;   // Own stream per process
  logic [31:0] rdy_seed = SEED ^ 32'hffff_0000;
  logic [31:0] apb_mem [0:1023];

  always #4 ACLK = ~ACLK;

  axi2apb_bridge u_dut (
    .ACLK (ACLK), .ARESETn (ARESETn),
    .awvalid_i (awvalid), .aw_i (aw), .awready_o (awready),
    .wvalid_i (wvalid), .w_i (w), .wready_o (wready),
    .arvalid_i (arvalid), .ar_i (ar), .arready_o (arready),
    .rvalid_o (rvalid), .r_o (r), .rready_i (rready),
    .bvalid_o (bvalid), .b_o (b), .bready_i (bready),
    .psel_o (psel), .penable_o (penable), .apb_o (apb),
    .prdata_i (prdata), .pready_i (pready), .pslverr_i (pslverr)
  );

  axi2apb_checker u_chk (
    .ACLK (ACLK), .ARESETn (ARESETn),
    .awvalid_i (awvalid), .awready_i (awready), .aw_i (aw),
    .wvalid_i (wvalid), .wready_i (wready), .w_i (w),
    .arvalid_i (arvalid), .arready_i (arready), .ar_i (ar),
    .rvalid_i (rvalid), .rready_i (rready), .r_i (r),
    .bvalid_i (bvalid), .bready_i (bready), .b_i (b),
    .psel_i (psel), .penable_i (penable), .pready_i (pready), .apb_i (apb),
    .check_cnt_o (chk_cnt), .err_cnt_o (err_cnt)
  );

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw(output logic [31:0] v);
    st_seed = lcg(st_seed);
    v       = st_seed;
  endtask

  // --------------------
  // APB slave model, 0 to 3 wait states
  initial
  begin : apb_slave
    logic [1:0] wait_left;
    for (int i = 0; i < 1024; i++)
      apb_mem[i[9:0]] = {~i[9:0], 6'h2b, i[9:0], 6'h15};
    pready    = 1'b0;
    pslverr   = 1'b0;
    prdata    = '0;
    wait_left = 2'd0;
    forever
    begin
      @(posedge ACLK);
      #1;
      pready  = 1'b0;
      pslverr = 1'b0;
      if (psel && !penable)
      begin
        slv_seed  = lcg(slv_seed);
        wait_left = slv_seed[17:16];
      end
      else if (psel && penable)
      begin
        if (wait_left == 2'd0)
        begin
          pready  = 1'b1;
          pslverr = apb.paddr[11];   // Error region, access still done
          prdata  = apb_mem[apb.paddr[11:2]];
          if (apb.pwrite)
            apb_mem[apb.paddr[11:2]] = apb.pwdata;
        end
        else
          wait_left = wait_left - 2'd1;
      end
    end
  end

  // RREADY and BREADY in random stretches
  initial
  begin : ready_stretch
    logic [1:0] hold;
    rready = 1'b0;
    bready = 1'b0;
    hold   = 2'd0;
    forever
    begin
      @(posedge ACLK);
      #1;
      if (hold == 2'd0)
      begin
        rdy_seed = lcg(rdy_seed);
        rready   = rdy_seed[20];
        bready   = rdy_seed[21];
        hold     = rdy_seed[25:24];
      end
      else
        hold = hold - 2'd1;
    end
  end

  // --------------------
  // AXI master tasks, called 1 ns after a rising edge
  task automatic wait_response();
    @(negedge ACLK);
    while (!((rvalid && rready) || (bvalid && bready)))
      @(negedge ACLK);
    @(posedge ACLK);
    #1;
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [2:0] size,
                           input logic [63:0] data);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    aw.addr = addr;
    aw.size = size;
    w.word  = data;
    @(negedge ACLK);
    while (!awready)
      @(negedge ACLK);
    @(posedge ACLK);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    wait_response();
  endtask

  task automatic axi_read(input logic [31:0] addr, input logic [2:0] size);
    arvalid = 1'b1;
    ar.addr = addr;
    ar.size = size;
    @(negedge ACLK);
    while (!arready)
      @(negedge ACLK);
    @(posedge ACLK);
    #1;
    arvalid = 1'b0;
    wait_response();
  endtask

  // AR and AW+W presented together, the read goes first
  task automatic read_write_same_cycle(input logic [31:0] raddr, input logic [31:0] waddr,
                                       input logic [63:0] data);
    arvalid = 1'b1;
    ar.addr = raddr;
    ar.size = SIZE_64;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    aw.addr = waddr;
    aw.size = 3'd2;
    w.word  = data;
    @(negedge ACLK);
    while (!arready)
      @(negedge ACLK);
    @(posedge ACLK);
    #1;
    arvalid = 1'b0;
    @(negedge ACLK);
    while (!awready)       // Write waits for the read response
      @(negedge ACLK);
    @(posedge ACLK);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    wait_response();
  endtask

  initial
  begin : stimulus
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] addr;
    logic [2:0]  size;
    ARESETn = 1'b0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    aw      = '0;
    w       = '0;
    ar      = '0;
    repeat (10) @(posedge ACLK);
    #1;
    ARESETn = 1'b1;
    @(posedge ACLK);
    #1;

    axi_write(32'h100, 3'd2, 64'hdead_0001_cafe_0100);
    axi_read(32'h100, 3'd2);
    axi_read(32'h104, 3'd2);
    axi_write(32'h10c, 3'd2, 64'h5555_010c_aaaa_0108);
    axi_read(32'h108, SIZE_64);
    axi_write(32'h200, SIZE_64, 64'h1111_2222_3333_4444);
    axi_read(32'h204, SIZE_64);     // Unaligned, served from 0x200
    axi_read(32'h206, 3'd1);        // Narrow size counts as one word
    axi_write(32'h808, SIZE_64, 64'h0bad_0bad_0808_0808);
    axi_read(32'h808, SIZE_64);
    axi_read(32'h900, 3'd2);
    read_write_same_cycle(32'h200, 32'h300, 64'h0000_0300_7777_0300);

    for (int n = 0; n < N_RANDOM; n++)
    begin
      draw(r0);
      draw(r1);
      draw(r2);
      addr = {20'h0, r0[11:0]};
      size = r0[12] ? SIZE_64 : 3'd2;
      if (r0[13])
        axi_write(addr, size, {r1, r2});
      else
        axi_read(addr, size);
    end

    repeat (5) @(posedge ACLK);
    $display("Done: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0 && chk_cnt > 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // Watchdog sized by the transaction count
  initial
  begin : watchdog
    repeat (N_TXN * 200 + 20) @(posedge ACLK);
    $display("Timeout: the bridge stopped completing AXI transactions");
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* axi2apb.f */
axi2apb_pkg.sv
axi_req_select.sv
apb_access_seq.sv
axi_resp_hold.sv
axi2apb_bridge.sv
axi2apb_checker.sv
tb_axi2apb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -sv --top-module tb_axi2apb \
    -f axi2apb.f --Mdir obj_dir ||
  { echo "Build failed"; exit 1; }
sim_out="$(./obj_dir/Vtb_axi2apb)"
echo "$sim_out"
echo "$sim_out" | grep -qF "Result: PASSED" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
